// File: flist.f
source/rs_pkg.sv
source/rs_if.sv
source/rs_entry.sv
source/rs_bank.sv
source/dual_issue_rs.sv
source/rs_top.sv
tests/tb_rs_top.sv

// File: run.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rs_top -f flist.f || exit 1
./obj_dir/Vtb_rs_top > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: source/dual_issue_rs.sv
`default_nettype none

module dual_issue_rs #(
  parameter int RS_SZ  = 4,
  parameter int RS_IDX = 2
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic [rs_pkg::LANES-1:0]                       inst_valid,
  input  rs_pkg::rs_inst_t [rs_pkg::LANES-1:0]           lane_inst,
  input  logic [rs_pkg::FU_N-1:0]                        exfu_free,
  input  logic [rs_pkg::FU_N-1:0]                        memfu_free,
  input  logic [rs_pkg::FU_N-1:0]                        multfu_free,
  input  logic [rs_pkg::CDB_N-1:0]                       cdb_valid,
  input  logic [rs_pkg::CDB_N-1:0][rs_pkg::PRF_IDX-1:0]  cdb_tag,
  input  logic [rs_pkg::LANES-1:0][RS_SZ-1:0]            entry_flush,
  output logic [rs_pkg::LANES-1:0]                       rs_stall,
  output logic [rs_pkg::LANES-1:0]                       en_out,
  output logic [rs_pkg::LANES-1:0][rs_pkg::FU_IDX-1:0]   fu_sel_out,
  output rs_pkg::rs_inst_t [rs_pkg::LANES-1:0]           iss_inst,
  output logic [rs_pkg::LANES-1:0][RS_IDX-1:0]           iss_slot
);
  import rs_pkg::*;

  dispatch_if                  disp0 ();
  dispatch_if                  disp1 ();
  issue_if #(.RS_IDX(RS_IDX))  iss0 ();
  issue_if #(.RS_IDX(RS_IDX))  iss1 ();

  logic [2:0][FU_N-1:0] free_b0;
  logic [2:0][FU_N-1:0] free_b1;
  logic [2:0][FU_N-1:0] taken0;  // Unit claimed by bank 0
  logic [FU_IDX-1:0]    sel0;
  logic [FU_IDX-1:0]    sel1;

  function automatic logic [FU_IDX-1:0] lowest_unit(input logic [FU_N-1:0] v);
    logic [FU_IDX-1:0] idx;
    idx = '0;
    for (int j = FU_N-1; j >= 0; j--) begin
      if (v[j]) idx = FU_IDX'(j);
    end
    return idx;
  endfunction

  // Bank 0 first, bank 1 overflows when it fills
  assign disp0.valid = inst_valid[0] & ~disp0.full;
  assign disp0.inst  = lane_inst[0];
  assign disp1.valid = ~disp1.full &
                       ((inst_valid[1] & ~disp0.full) | (inst_valid[0] & disp0.full));
  assign disp1.inst  = disp0.full ? lane_inst[0] : lane_inst[1];

  assign rs_stall[0] = disp0.full & disp1.full;
  assign rs_stall[1] = disp0.full | disp1.full;

  assign free_b0[FU_ALU]  = exfu_free;
  assign free_b0[FU_MEM]  = memfu_free;
  assign free_b0[FU_MULT] = multfu_free;

  assign iss0.avail = {|free_b0[FU_MULT], |free_b0[FU_MEM], |free_b0[FU_ALU]};
  assign sel0       = lowest_unit(free_b0[iss0.cls]);

  always_comb begin
    taken0 = '0;
    if (iss0.en) taken0[iss0.cls][sel0] = 1'b1;
  end

  // Whatever bank 0 left over
  assign free_b1    = free_b0 & ~taken0;
  assign iss1.avail = {|free_b1[FU_MULT], |free_b1[FU_MEM], |free_b1[FU_ALU]};
  assign sel1       = lowest_unit(free_b1[iss1.cls]);

  rs_bank #(.RS_SZ(RS_SZ), .RS_IDX(RS_IDX)) bank0_inst (
    .clk       (clk),
    .reset     (reset),
    .disp      (disp0.bank),
    .iss       (iss0.bank),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .flush     (entry_flush[0])
  );

  rs_bank #(.RS_SZ(RS_SZ), .RS_IDX(RS_IDX)) bank1_inst (
    .clk       (clk),
    .reset     (reset),
    .disp      (disp1.bank),
    .iss       (iss1.bank),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .flush     (entry_flush[1])
  );

  assign en_out     = {iss1.en, iss0.en};
  assign fu_sel_out = {sel1, sel0};
  assign iss_inst   = {iss1.inst, iss0.inst};
  assign iss_slot   = {iss1.slot, iss0.slot};

  // Both banks never land on one unit
  assert property (@(posedge clk) disable iff (reset)
    (iss0.en && iss1.en && iss0.cls == iss1.cls) |-> sel0 != sel1);

endmodule

`default_nettype wire

// File: source/rs_bank.sv
`default_nettype none

module rs_bank #(
  parameter int RS_SZ  = 4,
  parameter int RS_IDX = 2
) (
  input  logic                                          clk,
  input  logic                                          reset,
  dispatch_if.bank                                      disp,
  issue_if.bank                                         iss,
  input  logic [rs_pkg::CDB_N-1:0]                      cdb_valid,
  input  logic [rs_pkg::CDB_N-1:0][rs_pkg::PRF_IDX-1:0] cdb_tag,
  input  logic [RS_SZ-1:0]                              flush
);
  import rs_pkg::*;

  logic [RS_SZ-1:0]  busy;
  logic [RS_SZ-1:0]  ready;
  logic [RS_SZ-1:0]  cand;
  logic [RS_SZ-1:0]  load;
  logic [RS_SZ-1:0]  clear;
  fu_class_t         cls [RS_SZ];
  rs_inst_t          slot_inst [RS_SZ];
  logic [RS_IDX-1:0] alloc_sel;
  logic [RS_IDX-1:0] iss_sel;
  logic              iss_hit;

  assign disp.full = &busy;

  // Lowest empty slot
  always_comb begin
    alloc_sel = '0;
    for (int i = RS_SZ-1; i >= 0; i--) begin
      if (!busy[i]) alloc_sel = RS_IDX'(i);
    end
  end

  // Lowest ready entry whose class has a unit
  always_comb begin
    iss_hit = 1'b0;
    iss_sel = '0;
    for (int i = RS_SZ-1; i >= 0; i--) begin
      if (cand[i]) begin
        iss_hit = 1'b1;
        iss_sel = RS_IDX'(i);
      end
    end
  end

  for (genvar i = 0; i < RS_SZ; i++) begin : g_entry
    assign cand[i]  = ready[i] & ~flush[i] & iss.avail[cls[i]];  // Flush wins over issue
    assign load[i]  = disp.valid & ~disp.full & (alloc_sel == RS_IDX'(i));
    assign clear[i] = flush[i] | (iss_hit & (iss_sel == RS_IDX'(i)));

    rs_entry entry_inst (
      .clk       (clk),
      .reset     (reset),
      .load      (load[i]),
      .inst_in   (disp.inst),
      .clear     (clear[i]),
      .cdb_valid (cdb_valid),
      .cdb_tag   (cdb_tag),
      .busy      (busy[i]),
      .ready     (ready[i]),
      .cls       (cls[i]),
      .inst_out  (slot_inst[i])
    );
  end

  assign iss.en   = iss_hit;
  assign iss.slot = iss_sel;
  assign iss.cls  = cls[iss_sel];
  assign iss.inst = slot_inst[iss_sel];

  // Issue only ever reads an occupied entry
  assert property (@(posedge clk) disable iff (reset) iss.en |-> busy[iss_sel]);

  // Steering never pushes into a full bank
  assert property (@(posedge clk) disable iff (reset) disp.valid |-> !disp.full);

endmodule

`default_nettype wire

// File: source/rs_entry.sv
`default_nettype none

module rs_entry (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      load,
  input  rs_pkg::rs_inst_t                          inst_in,
  input  logic                                      clear,
  input  logic [rs_pkg::CDB_N-1:0]                  cdb_valid,
  input  logic [rs_pkg::CDB_N-1:0][rs_pkg::PRF_IDX-1:0] cdb_tag,
  output logic                                      busy,
  output logic                                      ready,
  output rs_pkg::fu_class_t                         cls,
  output rs_pkg::rs_inst_t                          inst_out
);
  import rs_pkg::*;

  rs_inst_t           inst_q;
  logic               busy_q;
  logic [PRF_IDX-1:0] src_a;
  logic [PRF_IDX-1:0] src_b;
  logic               wake_a;
  logic               wake_b;

  // Tags come from the incoming instruction on a load
  assign src_a = load ? inst_in.prega : inst_q.prega;
  assign src_b = load ? inst_in.pregb : inst_q.pregb;

  always_comb begin
    wake_a = 1'b0;
    wake_b = 1'b0;
    for (int c = 0; c < CDB_N; c++) begin
      if (cdb_valid[c] && cdb_tag[c] == src_a) wake_a = 1'b1;
      if (cdb_valid[c] && cdb_tag[c] == src_b) wake_b = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (load) begin
      busy_q <= 1'b1;
    end else if (clear) begin
      busy_q <= 1'b0;  // Issued or flushed
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      inst_q             <= inst_in;
      inst_q.prega_valid <= inst_in.prega_valid | wake_a;
      inst_q.pregb_valid <= inst_in.pregb_valid | wake_b;
    end else begin
      if (wake_a) inst_q.prega_valid <= 1'b1;
      if (wake_b) inst_q.pregb_valid <= 1'b1;
    end
  end

  assign busy     = busy_q;
  assign ready    = busy_q & inst_q.prega_valid & inst_q.pregb_valid;
  assign cls      = fu_class_of(inst_q);
  assign inst_out = inst_q;

  // Bank allocation only ever targets an empty entry
  assert property (@(posedge clk) disable iff (reset) load |-> !busy_q);

endmodule

`default_nettype wire

// File: source/rs_if.sv
`default_nettype none

// Steering logic to one station bank
interface dispatch_if;
  import rs_pkg::*;

  logic     valid;
  rs_inst_t inst;
  logic     full;  // No free slot this cycle

  modport steer (
    output valid,
    output inst,
    input  full
  );

  modport bank (
    input  valid,
    input  inst,
    output full
  );
endinterface

// Station bank to unit grant
interface issue_if #(
  parameter int RS_IDX = 2
);
  import rs_pkg::*;

  logic [2:0]        avail;  // Indexed by fu_class_t
  logic              en;
  fu_class_t         cls;
  logic [RS_IDX-1:0] slot;
  rs_inst_t          inst;

  modport grant (
    output avail,
    input  en,
    input  cls,
    input  slot,
    input  inst
  );

  modport bank (
    input  avail,
    output en,
    output cls,
    output slot,
    output inst
  );
endinterface

`default_nettype wire

// File: source/rs_pkg.sv
`default_nettype none

package rs_pkg;

  localparam int LANES   = 2;
  localparam int PRF_IDX = 6;
  localparam int ROB_IDX = 5;
  localparam int CDB_N   = 2;
  localparam int FU_N    = 2;
  localparam int FU_IDX  = $clog2(FU_N);  // Unit select width

  typedef enum logic [1:0] {
    FU_ALU  = 2'd0,
    FU_MEM  = 2'd1,
    FU_MULT = 2'd2
  } fu_class_t;

  localparam logic [4:0] ALU_MULQ = 5'h0b;

  // Renamed instruction as it sits in a station
  typedef struct packed {
    logic [PRF_IDX-1:0] prega;
    logic [PRF_IDX-1:0] pregb;
    logic [PRF_IDX-1:0] pdest;
    logic               prega_valid;
    logic               pregb_valid;
    logic [4:0]         alu_op;
    logic               rd_mem;
    logic               wr_mem;
    logic [31:0]        inst;
    logic [63:0]        npc;
    logic               cond_branch;
    logic               uncond_branch;
    logic [ROB_IDX-1:0] rob_idx;
  } rs_inst_t;

  function automatic fu_class_t fu_class_of(input rs_inst_t i);
    if (i.rd_mem || i.wr_mem) begin
      return FU_MEM;
    end
    if (i.alu_op == ALU_MULQ) begin
      return FU_MULT;
    end
    return FU_ALU;
  endfunction

endpackage

`default_nettype wire

// File: source/rs_top.sv
`default_nettype none

module rs_top #(
  parameter int RS_SZ  = 4,
  parameter int RS_IDX = $clog2(RS_SZ)
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [rs_pkg::LANES-1:0]                  inst_valid,
  input  logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  prega_idx,
  input  logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  pregb_idx,
  input  logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  pdest_idx,
  input  logic [rs_pkg::LANES-1:0]                  prega_valid,
  input  logic [rs_pkg::LANES-1:0]                  pregb_valid,
  input  logic [rs_pkg::LANES*5-1:0]                alu_op,
  input  logic [rs_pkg::LANES-1:0]                  rd_mem,
  input  logic [rs_pkg::LANES-1:0]                  wr_mem,
  input  logic [rs_pkg::LANES*32-1:0]               rs_ir,
  input  logic [rs_pkg::LANES*64-1:0]               npc,
  input  logic [rs_pkg::LANES-1:0]                  cond_branch,
  input  logic [rs_pkg::LANES-1:0]                  uncond_branch,
  input  logic [rs_pkg::FU_N-1:0]                   exfu_free,
  input  logic [rs_pkg::FU_N-1:0]                   memfu_free,
  input  logic [rs_pkg::FU_N-1:0]                   multfu_free,
  input  logic [rs_pkg::CDB_N-1:0]                  cdb_valid,
  input  logic [rs_pkg::CDB_N*rs_pkg::PRF_IDX-1:0]  cdb_tag,
  input  logic [rs_pkg::LANES*RS_SZ-1:0]            entry_flush,
  input  logic [rs_pkg::LANES*rs_pkg::ROB_IDX-1:0]  rob_idx,
  output logic [rs_pkg::LANES-1:0]                  rs_stall,
  output logic [rs_pkg::LANES-1:0]                  en_out,
  output logic [rs_pkg::LANES*rs_pkg::FU_IDX-1:0]   fu_sel_out,
  output logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  pdest_idx_out,
  output logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  prega_idx_out,
  output logic [rs_pkg::LANES*rs_pkg::PRF_IDX-1:0]  pregb_idx_out,
  output logic [rs_pkg::LANES*5-1:0]                alu_op_out,
  output logic [rs_pkg::LANES-1:0]                  rd_mem_out,
  output logic [rs_pkg::LANES-1:0]                  wr_mem_out,
  output logic [rs_pkg::LANES*32-1:0]               rs_ir_out,
  output logic [rs_pkg::LANES*64-1:0]               npc_out,
  output logic [rs_pkg::LANES*rs_pkg::ROB_IDX-1:0]  rob_idx_out,
  output logic [rs_pkg::LANES*RS_IDX-1:0]           rs_idx_out
);
  import rs_pkg::*;

  rs_inst_t [LANES-1:0] lane_inst;
  rs_inst_t [LANES-1:0] iss_inst;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_inst[l].prega         = prega_idx[l*PRF_IDX +: PRF_IDX];
      lane_inst[l].pregb         = pregb_idx[l*PRF_IDX +: PRF_IDX];
      lane_inst[l].pdest         = pdest_idx[l*PRF_IDX +: PRF_IDX];
      lane_inst[l].prega_valid   = prega_valid[l];
      lane_inst[l].pregb_valid   = pregb_valid[l];
      lane_inst[l].alu_op        = alu_op[l*5 +: 5];
      lane_inst[l].rd_mem        = rd_mem[l];
      lane_inst[l].wr_mem        = wr_mem[l];
      lane_inst[l].inst          = rs_ir[l*32 +: 32];
      lane_inst[l].npc           = npc[l*64 +: 64];
      lane_inst[l].cond_branch   = cond_branch[l];
      lane_inst[l].uncond_branch = uncond_branch[l];
      lane_inst[l].rob_idx       = rob_idx[l*ROB_IDX +: ROB_IDX];
    end
  end

  dual_issue_rs #(.RS_SZ(RS_SZ), .RS_IDX(RS_IDX)) dual_issue_rs_inst (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .lane_inst   (lane_inst),
    .exfu_free   (exfu_free),
    .memfu_free  (memfu_free),
    .multfu_free (multfu_free),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .entry_flush (entry_flush),
    .rs_stall    (rs_stall),
    .en_out      (en_out),
    .fu_sel_out  (fu_sel_out),
    .iss_inst    (iss_inst),
    .iss_slot    (rs_idx_out)
  );

  // Per bank outputs, bank 0 in the low slice
  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      pdest_idx_out[b*PRF_IDX +: PRF_IDX] = iss_inst[b].pdest;
      prega_idx_out[b*PRF_IDX +: PRF_IDX] = iss_inst[b].prega;
      pregb_idx_out[b*PRF_IDX +: PRF_IDX] = iss_inst[b].pregb;
      alu_op_out[b*5 +: 5]                = iss_inst[b].alu_op;
      rd_mem_out[b]                       = iss_inst[b].rd_mem;
      wr_mem_out[b]                       = iss_inst[b].wr_mem;
      rs_ir_out[b*32 +: 32]               = iss_inst[b].inst;
      npc_out[b*64 +: 64]                 = iss_inst[b].npc;
      rob_idx_out[b*ROB_IDX +: ROB_IDX]   = iss_inst[b].rob_idx;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_rs_top.sv
`default_nettype none

module tb_rs_top;
  timeunit 1ns;
  timeprecision 100ps;
  import rs_pkg::*;

  localparam int RS_SZ       = 4;
  localparam int RS_IDX      = 2;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 200;
  localparam int CLK_PERIOD  = 8;

  logic                         clk;
  logic                         reset;
  logic [LANES-1:0]             inst_valid;
  logic [LANES*PRF_IDX-1:0]     prega_idx;
  logic [LANES*PRF_IDX-1:0]     pregb_idx;
  logic [LANES*PRF_IDX-1:0]     pdest_idx;
  logic [LANES-1:0]             prega_valid;
  logic [LANES-1:0]             pregb_valid;
  logic [LANES*5-1:0]           alu_op;
  logic [LANES-1:0]             rd_mem;
  logic [LANES-1:0]             wr_mem;
  logic [LANES*32-1:0]          rs_ir;
  logic [LANES*64-1:0]          npc;
  logic [LANES-1:0]             cond_branch;
  logic [LANES-1:0]             uncond_branch;
  logic [FU_N-1:0]              exfu_free;
  logic [FU_N-1:0]              memfu_free;
  logic [FU_N-1:0]              multfu_free;
  logic [CDB_N-1:0]             cdb_valid;
  logic [CDB_N*PRF_IDX-1:0]     cdb_tag;
  logic [LANES*RS_SZ-1:0]       entry_flush;
  logic [LANES*ROB_IDX-1:0]     rob_idx;
  logic [LANES-1:0]             rs_stall;
  logic [LANES-1:0]             en_out;
  logic [LANES*FU_IDX-1:0]      fu_sel_out;
  logic [LANES*PRF_IDX-1:0]     pdest_idx_out;
  logic [LANES*PRF_IDX-1:0]     prega_idx_out;
  logic [LANES*PRF_IDX-1:0]     pregb_idx_out;
  logic [LANES*5-1:0]           alu_op_out;
  logic [LANES-1:0]             rd_mem_out;
  logic [LANES-1:0]             wr_mem_out;
  logic [LANES*32-1:0]          rs_ir_out;
  logic [LANES*64-1:0]          npc_out;
  logic [LANES*ROB_IDX-1:0]     rob_idx_out;
  logic [LANES*RS_IDX-1:0]      rs_idx_out;

  int          errors;
  int          checks;
  int          tests_failed;
  int          start_errors;
  string       cur_test;
  logic [31:0] lcg_state;

  rs_top #(.RS_SZ(RS_SZ), .RS_IDX(RS_IDX)) rs_top_inst (
    .clk           (clk),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .prega_idx     (prega_idx),
    .pregb_idx     (pregb_idx),
    .pdest_idx     (pdest_idx),
    .prega_valid   (prega_valid),
    .pregb_valid   (pregb_valid),
    .alu_op        (alu_op),
    .rd_mem        (rd_mem),
    .wr_mem        (wr_mem),
    .rs_ir         (rs_ir),
    .npc           (npc),
    .cond_branch   (cond_branch),
    .uncond_branch (uncond_branch),
    .exfu_free     (exfu_free),
    .memfu_free    (memfu_free),
    .multfu_free   (multfu_free),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .entry_flush   (entry_flush),
    .rob_idx       (rob_idx),
    .rs_stall      (rs_stall),
    .en_out        (en_out),
    .fu_sel_out    (fu_sel_out),
    .pdest_idx_out (pdest_idx_out),
    .prega_idx_out (prega_idx_out),
    .pregb_idx_out (pregb_idx_out),
    .alu_op_out    (alu_op_out),
    .rd_mem_out    (rd_mem_out),
    .wr_mem_out    (wr_mem_out),
    .rs_ir_out     (rs_ir_out),
    .npc_out       (npc_out),
    .rob_idx_out   (rob_idx_out),
    .rs_idx_out    (rs_idx_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all tests finished, in test %s", cur_test);
    $display("sim failed");
    $finish;
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    start_errors = errors;
  endtask

  task automatic finish_test();
    if (errors == start_errors) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", cur_test, errors - start_errors);
    end
  endtask

  task automatic idle_inputs();
    inst_valid    = '0;
    prega_idx     = '0;
    pregb_idx     = '0;
    pdest_idx     = '0;
    prega_valid   = '0;
    pregb_valid   = '0;
    alu_op        = '0;
    rd_mem        = '0;
    wr_mem        = '0;
    rs_ir         = '0;
    npc           = '0;
    cond_branch   = '0;
    uncond_branch = '0;
    exfu_free     = 2'b11;
    memfu_free    = 2'b11;
    multfu_free   = 2'b11;
    cdb_valid     = '0;
    cdb_tag       = '0;
    entry_flush   = '0;
    rob_idx       = '0;
  endtask

  task automatic drive_lane(input int lane, input logic [5:0] pa, input logic [5:0] pb,
                            input logic pa_v, input logic pb_v, input logic [5:0] dest,
                            input logic [4:0] op, input logic rd, input logic wr,
                            input logic [31:0] ir, input logic [63:0] pc,
                            input logic [4:0] rob);
    inst_valid[lane]                    = 1'b1;
    prega_idx[lane*PRF_IDX +: PRF_IDX]  = pa;
    pregb_idx[lane*PRF_IDX +: PRF_IDX]  = pb;
    prega_valid[lane]                   = pa_v;
    pregb_valid[lane]                   = pb_v;
    pdest_idx[lane*PRF_IDX +: PRF_IDX]  = dest;
    alu_op[lane*5 +: 5]                 = op;
    rd_mem[lane]                        = rd;
    wr_mem[lane]                        = wr;
    rs_ir[lane*32 +: 32]                = ir;
    npc[lane*64 +: 64]                  = pc;
    rob_idx[lane*ROB_IDX +: ROB_IDX]    = rob;
  endtask

  // One bank's issue port against the expected entry
  task automatic check_issue(input int bank, input logic [4:0] rob,
                             input logic [RS_IDX-1:0] slot, input logic [FU_IDX-1:0] unit);
    check("en", 64'(1), 64'(en_out[bank]));
    check("unit", 64'(unit), 64'(fu_sel_out[bank*FU_IDX +: FU_IDX]));
    check("slot", 64'(slot), 64'(rs_idx_out[bank*RS_IDX +: RS_IDX]));
    check("rob", 64'(rob), 64'(rob_idx_out[bank*ROB_IDX +: ROB_IDX]));
  endtask

  task automatic reset_state();
    start_test("reset_state");
    #1;
    check("en after reset", 64'(0), 64'(en_out));
    check("stall after reset", 64'(0), 64'(rs_stall));
    @(negedge clk);
    #1;
    check("en idle", 64'(0), 64'(en_out));
    finish_test();
  endtask

  task automatic single_alu_issue();
    logic [31:0] r;
    logic [63:0] pc;
    logic [31:0] ir;
    logic [5:0]  dest;
    logic [4:0]  rob;
    start_test("single_alu_issue");
    r    = lcg_next();
    dest = r[29:24];
    rob  = r[20:16];
    pc   = {lcg_next(), lcg_next()};
    ir   = lcg_next();
    @(negedge clk);
    idle_inputs();
    drive_lane(0, 6'd1, 6'd2, 1'b1, 1'b1, dest, 5'd0, 1'b0, 1'b0, ir, pc, rob);
    #1;
    check("en before accept", 64'(0), 64'(en_out));
    check("stall", 64'(0), 64'(rs_stall));
    @(negedge clk);
    inst_valid = '0;
    #1;
    check_issue(0, rob, 2'd0, 1'b0);
    check("bank 1 en", 64'(0), 64'(en_out[1]));
    check("pdest", 64'(dest), 64'(pdest_idx_out[5:0]));
    check("prega", 64'(1), 64'(prega_idx_out[5:0]));
    check("pregb", 64'(2), 64'(pregb_idx_out[5:0]));
    check("npc", pc, npc_out[63:0]);
    check("ir", 64'(ir), 64'(rs_ir_out[31:0]));
    @(negedge clk);
    #1;
    check("en after issue", 64'(0), 64'(en_out));
    finish_test();
  endtask

  task automatic cdb_wakeup();
    logic [31:0] r;
    logic [5:0]  tag;
    logic [5:0]  tag_n;
    logic [5:0]  dest;
    logic [4:0]  rob;
    start_test("cdb_wakeup");
    r     = lcg_next();
    tag   = r[21:16];
    tag_n = ~tag;
    dest  = r[27:22];
    rob   = r[12:8];
    @(negedge clk);
    idle_inputs();
    // Store waiting on its address register
    drive_lane(0, tag, tag_n, 1'b0, 1'b1, dest, 5'd0, 1'b0, 1'b1, r, 64'(r), rob);
    repeat (2) begin
      @(negedge clk);
      inst_valid = '0;
      #1;
      check("en while waiting", 64'(0), 64'(en_out));
    end
    @(negedge clk);
    cdb_valid = 2'b11;
    cdb_tag   = {tag, tag ^ 6'h20};  // Match on slot 1 only
    #1;
    check("en in broadcast cycle", 64'(0), 64'(en_out));
    @(negedge clk);
    cdb_valid = '0;
    #1;
    check_issue(0, rob, 2'd0, 1'b0);
    check("pdest", 64'(dest), 64'(pdest_idx_out[5:0]));
    check("prega", 64'(tag), 64'(prega_idx_out[5:0]));
    check("pregb", 64'(tag_n), 64'(pregb_idx_out[5:0]));
    check("wr_mem", 64'(1), 64'(wr_mem_out[0]));
    check("rd_mem", 64'(0), 64'(rd_mem_out[0]));
    @(negedge clk);
    #1;
    check("en after issue", 64'(0), 64'(en_out));
    finish_test();
  endtask

  task automatic mem_backpressure();
    logic [31:0] r;
    logic [4:0]  rob;
    start_test("mem_backpressure");
    r   = lcg_next();
    rob = r[20:16];
    @(negedge clk);
    idle_inputs();
    memfu_free = 2'b00;
    drive_lane(0, 6'd5, 6'd6, 1'b1, 1'b1, r[29:24], 5'd0, 1'b1, 1'b0, r, 64'(r), rob);
    repeat (5) begin
      @(negedge clk);
      inst_valid = '0;
      #1;
      check("en with no mem unit", 64'(0), 64'(en_out));
    end
    @(negedge clk);
    memfu_free = 2'b10;
    #1;
    check_issue(0, rob, 2'd0, 1'b1);
    check("rd_mem", 64'(1), 64'(rd_mem_out[0]));
    check("wr_mem", 64'(0), 64'(wr_mem_out[0]));
    @(negedge clk);
    #1;
    check("en after issue", 64'(0), 64'(en_out));
    finish_test();
  endtask

  task automatic mult_grant();
    logic [31:0] r;
    logic [4:0]  rob0;
    logic [4:0]  rob1;
    start_test("mult_grant");
    r    = lcg_next();
    rob0 = r[20:16];
    rob1 = r[28:24];
    @(negedge clk);
    idle_inputs();
    multfu_free = 2'b10;
    drive_lane(0, 6'd7, 6'd8, 1'b1, 1'b1, 6'd9, ALU_MULQ, 1'b0, 1'b0, r, 64'(r), rob0);
    drive_lane(1, 6'd10, 6'd11, 1'b1, 1'b1, 6'd12, ALU_MULQ, 1'b0, 1'b0, ~r, 64'(~r), rob1);
    #1;
    check("stall", 64'(0), 64'(rs_stall));
    @(negedge clk);
    inst_valid = '0;
    #1;
    check_issue(0, rob0, 2'd0, 1'b1);
    check("alu_op bank 0", 64'(ALU_MULQ), 64'(alu_op_out[4:0]));
    check("bank 1 waits", 64'(0), 64'(en_out[1]));
    @(negedge clk);
    #1;
    check_issue(1, rob1, 2'd0, 1'b1);
    check("alu_op bank 1", 64'(ALU_MULQ), 64'(alu_op_out[9:5]));
    check("bank 0 en", 64'(0), 64'(en_out[0]));
    @(negedge clk);
    #1;
    check("en after issue", 64'(0), 64'(en_out));
    finish_test();
  endtask

  task automatic fill_and_flush();
    logic [4:0] exp_rob;
    start_test("fill_and_flush");
    @(negedge clk);
    idle_inputs();
    exfu_free   = 2'b00;
    memfu_free  = 2'b00;
    multfu_free = 2'b00;
    for (int i = 0; i < 8; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      drive_lane(0, 6'd3, 6'd4, 1'b1, 1'b1, 6'(i), 5'd0, 1'b0, 1'b0, 32'(i), 64'(i), 5'(i));
      #1;
      check("stall while filling", (i < 4) ? 64'h0 : 64'h2, 64'(rs_stall));
    end
    @(negedge clk);
    inst_valid     = '0;
    entry_flush[1] = 1'b1;  // Bank 0 slot 1
    #1;
    check("stall with both full", 64'h3, 64'(rs_stall));
    @(negedge clk);
    entry_flush = '0;
    drive_lane(0, 6'd3, 6'd4, 1'b1, 1'b1, 6'd8, 5'd0, 1'b0, 1'b0, 32'd8, 64'd8, 5'd8);
    #1;
    check("stall after flush", 64'h2, 64'(rs_stall));
    @(negedge clk);
    inst_valid = '0;
    exfu_free  = 2'b01;
    for (int k = 0; k < 8; k++) begin
      #1;
      if (k == 0) begin
        check("stall after reuse", 64'h3, 64'(rs_stall));
      end
      if (k < 4) begin
        exp_rob = (k == 1) ? 5'd8 : 5'(k);  // Reused slot holds the new entry
        check_issue(0, exp_rob, 2'(k), 1'b0);
        check("bank 1 idle", 64'(0), 64'(en_out[1]));
      end else begin
        check_issue(1, 5'(k), 2'(k - 4), 1'b0);
        check("bank 0 idle", 64'(0), 64'(en_out[0]));
      end
      @(negedge clk);
    end
    #1;
    check("en when drained", 64'(0), 64'(en_out));
    check("stall when drained", 64'(0), 64'(rs_stall));
    finish_test();
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    tests_failed = 0;
    start_errors = 0;
    cur_test     = "reset";
    lcg_state    = 32'd12;
    reset        = 1'b1;
    idle_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_state();
    single_alu_issue();
    cdb_wakeup();
    mem_backpressure();
    mult_grant();
    fill_and_flush();
    $display("tests: %0d, failed: %0d, checks: %0d, mismatches: %0d",
             N_TESTS, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
